/* verilog/exec_pkg.sv */
// Execute stage shared definitions.
// Holds the micro-op opcodes, register addresses, flag bit positions,
// the data word types and the architectural reset values.

package exec_pkg;

  // ##########################################################################
  // data types
  // ##########################################################################

  // single register width and the double width used by the multiplier.
  typedef logic [15:0] word_t;
  typedef logic [31:0] dword_t;

  // micro-op opcodes, one per ALU function plus the IP save.
  typedef enum logic [3:0] {
    OP_NOP    = 4'd0,
    OP_MOV    = 4'd1,
    OP_ADD    = 4'd2,
    OP_SUB    = 4'd3,
    OP_AND    = 4'd4,
    OP_OR     = 4'd5,
    OP_XOR    = 4'd6,
    OP_MUL    = 4'd7,
    OP_SAVEIP = 4'd8
  } exec_op_e;

  // ##########################################################################
  // register file addressing
  // ##########################################################################

  // addresses 0-7 are the general registers, 8-11 the segments.
  // in byte mode 0-3 name the low halves and 4-7 the high halves.
  typedef logic [3:0] reg_addr_t;

  localparam reg_addr_t REG_CX     = 4'd1;
  localparam reg_addr_t REG_DX     = 4'd2;
  localparam reg_addr_t REG_CS     = 4'd9;
  localparam reg_addr_t REG_IPSAVE = 4'd14;
  localparam reg_addr_t REG_IP     = 4'd15;

  // ##########################################################################
  // flags word
  // ##########################################################################

  typedef logic [8:0] flags_t;

  localparam int FLAG_CF = 0;
  localparam int FLAG_PF = 1;
  localparam int FLAG_AF = 2;
  localparam int FLAG_ZF = 3;
  localparam int FLAG_SF = 4;
  localparam int FLAG_TF = 5;
  localparam int FLAG_IF = 6;
  localparam int FLAG_DF = 7;
  localparam int FLAG_OF = 8;

  // the processor starts at the top of the first megabyte.
  localparam word_t CS_RESET = 16'hf000;
  localparam word_t IP_RESET = 16'hfff0;

endpackage

/* verilog/regfile_if.sv */
// Register file bus.
// Bundles the two read ports and the write port between the micro-op
// controller and the register file.

interface regfile_if;
  import exec_pkg::*;

  // read port a addresses the destination, read port b the source.
  reg_addr_t addr_a;
  reg_addr_t addr_b;
  logic      a_byte;
  logic      b_byte;
  word_t     a;
  word_t     b;

  // write port.
  // the upper half of d only matters for the high-word write to DX.
  reg_addr_t addr_d;
  dword_t    d;
  logic      wr;
  logic      wrhi;
  logic      wr_ip0;
  logic      word_op;

  // the controller drives addresses, strobes and write data.
  modport ctrl (
    output addr_a, addr_b, a_byte, b_byte,
    output addr_d, d, wr, wrhi, wr_ip0, word_op,
    input  a, b
  );

  // the register file only returns the read data.
  modport rfile (
    input  addr_a, addr_b, a_byte, b_byte,
    input  addr_d, d, wr, wrhi, wr_ip0, word_op,
    output a, b
  );

endinterface

/* verilog/exec_alu.sv */
// Execute stage ALU.
// Combinational move, add, subtract, logic and unsigned multiply on word
// or byte operands, producing a 32-bit result and the arithmetic flags.

module exec_alu (
  input  exec_pkg::exec_op_e op,
  input  exec_pkg::word_t    x,
  input  exec_pkg::word_t    y,
  input  logic               byte_op,
  output exec_pkg::dword_t   res,
  output logic               cf,
  output logic               pf,
  output logic               af,
  output logic               zf,
  output logic               sf,
  output logic               of
);
  import exec_pkg::*;

  dword_t      prod;
  logic [16:0] raw_w;
  logic [8:0]  raw_b;
  word_t       low;
  logic        is_arith;
  logic        x_sign;
  logic        y_sign;
  logic        hi_nz;

  // full 16 x 16 unsigned product.
  assign prod = {16'h0000, x} * {16'h0000, y};

  // word and byte results are formed side by side, each with a carry bit
  // on top; byte_op picks which one is used further down.
  always_comb begin
    raw_w = '0;
    raw_b = '0;
    case (op)
      OP_MOV: begin
        raw_w = {1'b0, y};
        raw_b = {1'b0, y[7:0]};
      end
      OP_ADD: begin
        raw_w = {1'b0, x} + {1'b0, y};
        raw_b = {1'b0, x[7:0]} + {1'b0, y[7:0]};
      end
      OP_SUB: begin
        raw_w = {1'b0, x} - {1'b0, y};
        raw_b = {1'b0, x[7:0]} - {1'b0, y[7:0]};
      end
      OP_AND: begin
        raw_w = {1'b0, x & y};
        raw_b = {1'b0, x[7:0] & y[7:0]};
      end
      OP_OR: begin
        raw_w = {1'b0, x | y};
        raw_b = {1'b0, x[7:0] | y[7:0]};
      end
      OP_XOR: begin
        raw_w = {1'b0, x ^ y};
        raw_b = {1'b0, x[7:0] ^ y[7:0]};
      end
      default: begin
        raw_w = '0;
        raw_b = '0;
      end
    endcase
  end

  // byte results are sign-extended into the low word.
  assign low = (op == OP_MUL) ? prod[15:0]
             : byte_op        ? {{8{raw_b[7]}}, raw_b[7:0]}
             :                  raw_w[15:0];
  assign res = (op == OP_MUL) ? prod : {16'h0000, low};

  // ##########################################################################
  // flags
  // ##########################################################################

  assign is_arith = (op == OP_ADD) || (op == OP_SUB);
  assign x_sign   = byte_op ? x[7] : x[15];
  assign y_sign   = byte_op ? y[7] : y[15];
  assign hi_nz    = |prod[31:16];

  // carry is the borrow for subtract; logic operations clear it.
  assign cf = (op == OP_MUL) ? hi_nz
            : is_arith       ? (byte_op ? raw_b[8] : raw_w[16])
            :                  1'b0;

  // overflow when the signs of operands and result disagree.
  assign of = (op == OP_MUL) ? hi_nz
            : (op == OP_ADD) ? (x_sign == y_sign) && (low[15] != x_sign)
            : (op == OP_SUB) ? (x_sign != y_sign) && (low[15] != x_sign)
            :                  1'b0;

  assign af = is_arith ? (x[4] ^ y[4] ^ low[4]) : 1'b0;
  // low[15] already holds the byte sign after extension.
  assign sf = low[15];
  assign zf = byte_op ? (low[7:0] == 8'h00) : (low == 16'h0000);
  assign pf = ~^low[7:0];

  // the multiplier only exists at word width.
  always_comb begin
    a_mul_word : assert final (!(op == OP_MUL && byte_op));
  end

endmodule

/* verilog/exec_regfile.sv */
// Register file of the execute stage.
// Sixteen 16-bit registers with 8086 byte-half addressing, a high-word
// write into DX, an IP save slot, the flags word and a CX-zero flag.

module exec_regfile (
  input  logic             clk,
  input  logic             rst,
  regfile_if.rfile         rf,
  input  exec_pkg::flags_t iflags,
  input  logic             wrfl,
  output exec_pkg::flags_t flags,
  output exec_pkg::word_t  cs,
  output exec_pkg::word_t  ip,
  output logic             cx_zero
);
  import exec_pkg::*;

  // storage for all sixteen registers.
  word_t regs [16];

  // ##########################################################################
  // read ports
  // ##########################################################################

  // a byte read of a general register picks one half and sign-extends it.
  // addresses 4-7 map onto the high halves of registers 0-3, so the base
  // register is needed as well as the addressed one.
  // anything at address 8 or above is always read as a full word.
  function automatic word_t sel_read(reg_addr_t addr, logic byte_sel,
                                     word_t full, word_t base);
    logic [7:0] half;
    half = addr[2] ? base[15:8] : full[7:0];
    if (byte_sel && !addr[3]) begin
      return {{8{half[7]}}, half};
    end
    return full;
  endfunction

  assign rf.a = sel_read(rf.addr_a, rf.a_byte, regs[rf.addr_a],
                         regs[{2'b00, rf.addr_a[1:0]}]);
  assign rf.b = sel_read(rf.addr_b, rf.b_byte, regs[rf.addr_b],
                         regs[{2'b00, rf.addr_b[1:0]}]);

  // code segment and instruction pointer go straight out.
  assign cs = regs[REG_CS];
  assign ip = regs[REG_IP];

  // a pending write to CX is looked at before it lands, so a loop
  // test in the next cycle sees the new count.
  assign cx_zero = (rf.wr && rf.addr_d == REG_CX) ? (rf.d[15:0] == 16'h0000)
                                                  : (regs[REG_CX] == 16'h0000);

  // ##########################################################################
  // write port
  // ##########################################################################

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= 16'h0000;
      end
      regs[REG_CS] <= CS_RESET;
      regs[REG_IP] <= IP_RESET;
      flags        <= '0;
    end else begin
      if (rf.wr) begin
        // word writes and every segment write store the full register.
        // a byte written to a segment register is sign-extended first.
        if (rf.word_op || rf.addr_d[3:2] == 2'b10) begin
          regs[rf.addr_d] <= rf.word_op ? rf.d[15:0]
                                        : {{8{rf.d[7]}}, rf.d[7:0]};
        end else if (rf.addr_d[3] == rf.addr_d[2]) begin
          // addresses 0-3 and 12-15 take the byte in the low half.
          regs[rf.addr_d][7:0] <= rf.d[7:0];
        end else begin
          // addresses 4-7 are AH, CH, DH and BH.
          regs[{2'b00, rf.addr_d[1:0]}][15:8] <= rf.d[7:0];
        end
      end
      // the upper product word of a multiply lands in DX.
      if (rf.wrhi) begin
        regs[REG_DX] <= rf.d[31:16];
      end
      if (rf.wr_ip0) begin
        regs[REG_IPSAVE] <= regs[REG_IP];
      end
      if (wrfl) begin
        flags <= iflags;
      end
    end
  end

  // ##########################################################################
  // checks
  // ##########################################################################

  // the controller must never let a multiply target DX, since the high
  // word and the low word would then race for the same register.
  a_wrhi_vs_dx : assert property (@(posedge clk) disable iff (rst)
    !(rf.wrhi && rf.wr && rf.word_op && rf.addr_d == REG_DX));

  // saving IP and an ordinary write to the save slot are exclusive.
  a_ipsave_once : assert property (@(posedge clk) disable iff (rst)
    !(rf.wr_ip0 && rf.wr && rf.addr_d == REG_IPSAVE));

endmodule

/* verilog/exec_uop_ctrl.sv */
// Micro-op controller.
// Turns one micro-op into register file addresses and write strobes,
// feeds the ALU and merges its flags with the control flags.

module exec_uop_ctrl (
  input  logic                clk,
  input  logic                rst,
  input  logic                uop_valid,
  input  exec_pkg::exec_op_e  uop_op,
  input  exec_pkg::reg_addr_t uop_dst,
  input  exec_pkg::reg_addr_t uop_src,
  input  logic                uop_use_imm,
  input  exec_pkg::word_t     uop_imm,
  input  logic                uop_word,
  regfile_if.ctrl             rf,
  input  exec_pkg::flags_t    flags,
  output exec_pkg::flags_t    iflags,
  output logic                wrfl,
  output exec_pkg::dword_t    result
);
  import exec_pkg::*;

  word_t src_val;
  logic  alu_cf, alu_pf, alu_af, alu_zf, alu_sf, alu_of;

  // destination on port a, source on port b.
  assign rf.addr_a  = uop_dst;
  assign rf.addr_b  = uop_src;
  assign rf.a_byte  = !uop_word;
  assign rf.b_byte  = !uop_word;
  assign src_val    = uop_use_imm ? uop_imm : rf.b;

  exec_alu u_alu (
    .op      (uop_op),
    .x       (rf.a),
    .y       (src_val),
    .byte_op (!uop_word),
    .res     (result),
    .cf      (alu_cf),
    .pf      (alu_pf),
    .af      (alu_af),
    .zf      (alu_zf),
    .sf      (alu_sf),
    .of      (alu_of)
  );

  // write back into the destination on the same edge.
  assign rf.addr_d  = uop_dst;
  assign rf.d       = result;
  assign rf.word_op = uop_word;
  assign rf.wr      = uop_valid && uop_op != OP_NOP && uop_op != OP_SAVEIP;
  assign rf.wrhi    = uop_valid && uop_op == OP_MUL;
  assign rf.wr_ip0  = uop_valid && uop_op == OP_SAVEIP;

  // a move leaves the flags alone.
  assign wrfl = uop_valid && uop_op inside {OP_ADD, OP_SUB, OP_AND, OP_OR,
                                            OP_XOR, OP_MUL};

  // TF, IF and DF are control bits and pass through unchanged.
  always_comb begin
    iflags          = '0;
    iflags[FLAG_CF] = alu_cf;
    iflags[FLAG_PF] = alu_pf;
    iflags[FLAG_AF] = alu_af;
    iflags[FLAG_ZF] = alu_zf;
    iflags[FLAG_SF] = alu_sf;
    iflags[FLAG_TF] = flags[FLAG_TF];
    iflags[FLAG_IF] = flags[FLAG_IF];
    iflags[FLAG_DF] = flags[FLAG_DF];
    iflags[FLAG_OF] = alu_of;
  end

  a_legal_op : assert property (@(posedge clk) disable iff (rst)
    uop_valid |-> uop_op inside {OP_NOP, OP_MOV, OP_ADD, OP_SUB, OP_AND,
                                 OP_OR, OP_XOR, OP_MUL, OP_SAVEIP});

endmodule

/* verilog/exec_unit.sv */
// Execute stage top level.
// Joins the micro-op controller and the register file over the register
// file bus and exposes the result, flags, cs, ip and the CX-zero flag.

module exec_unit (
  input  logic                clk,
  input  logic                rst,
  input  logic                uop_valid,
  input  exec_pkg::exec_op_e  uop_op,
  input  exec_pkg::reg_addr_t uop_dst,
  input  exec_pkg::reg_addr_t uop_src,
  input  logic                uop_use_imm,
  input  exec_pkg::word_t     uop_imm,
  input  logic                uop_word,
  output exec_pkg::dword_t    result,
  output exec_pkg::flags_t    flags,
  output exec_pkg::word_t     cs,
  output exec_pkg::word_t     ip,
  output logic                cx_zero
);
  import exec_pkg::*;

  // merged flags on their way back into the flags register.
  flags_t iflags;
  logic   wrfl;

  regfile_if rf_bus ();

  exec_uop_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .uop_valid   (uop_valid),
    .uop_op      (uop_op),
    .uop_dst     (uop_dst),
    .uop_src     (uop_src),
    .uop_use_imm (uop_use_imm),
    .uop_imm     (uop_imm),
    .uop_word    (uop_word),
    .rf          (rf_bus.ctrl),
    .flags       (flags),
    .iflags      (iflags),
    .wrfl        (wrfl),
    .result      (result)
  );

  exec_regfile u_regfile (
    .clk     (clk),
    .rst     (rst),
    .rf      (rf_bus.rfile),
    .iflags  (iflags),
    .wrfl    (wrfl),
    .flags   (flags),
    .cs      (cs),
    .ip      (ip),
    .cx_zero (cx_zero)
  );

endmodule

/* sim/tb_exec_unit.sv */
// Testbench for the execute stage.
// Drives random and directed micro-ops into the DUT and compares result,
// flags, cs, ip and the CX-zero flag with a register file model.

module tb_exec_unit;
  import exec_pkg::*;

  logic      clk;
  logic      rst;
  logic      uop_valid;
  exec_op_e  uop_op;
  reg_addr_t uop_dst;
  reg_addr_t uop_src;
  logic      uop_use_imm;
  word_t     uop_imm;
  logic      uop_word;
  dword_t    result;
  flags_t    flags;
  word_t     cs;
  word_t     ip;
  logic      cx_zero;

  // the model state always equals the DUT state after the last edge.
  word_t  m_regs [16];
  flags_t m_flags;
  int     errors;
  int     checks;

  exec_unit dut (
    .clk         (clk),
    .rst         (rst),
    .uop_valid   (uop_valid),
    .uop_op      (uop_op),
    .uop_dst     (uop_dst),
    .uop_src     (uop_src),
    .uop_use_imm (uop_use_imm),
    .uop_imm     (uop_imm),
    .uop_word    (uop_word),
    .result      (result),
    .flags       (flags),
    .cs          (cs),
    .ip          (ip),
    .cx_zero     (cx_zero)
  );

  always #5 clk = ~clk;

  // clock start, input defaults and a reset of four cycles.
  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    uop_valid   = 1'b0;
    uop_op      = OP_NOP;
    uop_dst     = '0;
    uop_src     = '0;
    uop_use_imm = 1'b0;
    uop_imm     = '0;
    uop_word    = 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
  end

  // ##########################################################################
  // compare tasks
  // ##########################################################################

  task automatic check_result(input string what, input dword_t got, input dword_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s is %08h, expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic check_flags(input string what, input flags_t got, input flags_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s is %03h, expected %03h", $time, what, got, exp);
    end
  endtask

  task automatic check_word(input string what, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s is %04h, expected %04h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // ##########################################################################
  // reference model
  // ##########################################################################

  // byte reads of 0-7 return one half, sign-extended. 4-7 are AH to BH.
  function automatic word_t model_read(reg_addr_t addr, logic is_byte);
    logic [7:0] half;
    if (!is_byte || addr[3]) begin
      return m_regs[addr];
    end
    if (addr[2]) begin
      half = m_regs[{2'b00, addr[1:0]}][15:8];
    end else begin
      half = m_regs[addr][7:0];
    end
    return {{8{half[7]}}, half};
  endfunction

  task automatic model_write(input reg_addr_t addr, input word_t d, input logic word);
    if (word) begin
      m_regs[addr] = d;
    end else if (addr >= 4'd8 && addr <= 4'd11) begin
      m_regs[addr] = {{8{d[7]}}, d[7:0]};
    end else if (addr >= 4'd4 && addr <= 4'd7) begin
      m_regs[{2'b00, addr[1:0]}][15:8] = d[7:0];
    end else begin
      m_regs[addr][7:0] = d[7:0];
    end
  endtask

  // works out the expected result and flags at the operand width.
  task automatic predict(input exec_op_e op, input word_t x, input word_t y,
                         input logic is_byte, output dword_t res, output flags_t fl);
    logic [31:0] xs;
    logic [31:0] ys;
    logic [31:0] r;
    int          msb;
    msb = is_byte ? 7 : 15;
    xs  = is_byte ? {24'h0, x[7:0]} : {16'h0, x};
    ys  = is_byte ? {24'h0, y[7:0]} : {16'h0, y};
    fl  = m_flags;
    case (op)
      OP_MOV:  r = ys;
      OP_ADD:  r = xs + ys;
      OP_SUB:  r = xs - ys;
      OP_AND:  r = xs & ys;
      OP_OR:   r = xs | ys;
      OP_XOR:  r = xs ^ ys;
      OP_MUL:  r = xs * ys;
      default: r = 32'h0;
    endcase
    if (op == OP_MUL) begin
      res = r;
    end else if (is_byte) begin
      res = {16'h0, {8{r[7]}}, r[7:0]};
    end else begin
      res = {16'h0, r[15:0]};
    end
    // a move, a NOP and the IP save keep the whole flags word.
    if (op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_MUL}) begin
      fl[FLAG_ZF] = is_byte ? (r[7:0] == 8'h00) : (r[15:0] == 16'h0000);
      fl[FLAG_SF] = r[msb];
      fl[FLAG_PF] = ~^r[7:0];
      fl[FLAG_CF] = 1'b0;
      fl[FLAG_OF] = 1'b0;
      fl[FLAG_AF] = 1'b0;
      if (op == OP_ADD) begin
        fl[FLAG_CF] = r[msb + 1];
        fl[FLAG_OF] = (xs[msb] == ys[msb]) && (r[msb] != xs[msb]);
        fl[FLAG_AF] = xs[4] ^ ys[4] ^ r[4];
      end else if (op == OP_SUB) begin
        fl[FLAG_CF] = xs < ys;
        fl[FLAG_OF] = (xs[msb] != ys[msb]) && (r[msb] != xs[msb]);
        fl[FLAG_AF] = xs[4] ^ ys[4] ^ r[4];
      end else if (op == OP_MUL) begin
        fl[FLAG_CF] = r[31:16] != 16'h0;
        fl[FLAG_OF] = r[31:16] != 16'h0;
      end
    end
  endtask

  // ##########################################################################
  // stimulus
  // ##########################################################################

  // the state left by the previous edge is seen one cycle after its micro-op.
  task automatic check_state();
    check_flags("flags", flags, m_flags);
    check_word("cs", cs, m_regs[REG_CS]);
    check_word("ip", ip, m_regs[REG_IP]);
  endtask

  task automatic issue(input exec_op_e op, input reg_addr_t dst, input reg_addr_t src,
                       input logic use_imm, input word_t imm, input logic word);
    word_t  x;
    word_t  y;
    dword_t exp_res;
    flags_t exp_fl;
    logic   writes;
    logic   exp_cxz;
    @(posedge clk);
    uop_valid   <= 1'b1;
    uop_op      <= op;
    uop_dst     <= dst;
    uop_src     <= src;
    uop_use_imm <= use_imm;
    uop_imm     <= imm;
    uop_word    <= word;
    @(negedge clk);
    check_state();
    x = model_read(dst, !word);
    y = use_imm ? imm : model_read(src, !word);
    predict(op, x, y, !word, exp_res, exp_fl);
    writes = op != OP_NOP && op != OP_SAVEIP;
    // a CX write shows up on cx_zero in the same cycle.
    exp_cxz = (writes && dst == REG_CX) ? (exp_res[15:0] == 16'h0000)
                                        : (m_regs[REG_CX] == 16'h0000);
    if (writes) begin
      check_result("result", result, exp_res);
    end
    check_bit("cx_zero", cx_zero, exp_cxz);
    if (writes) begin
      model_write(dst, exp_res[15:0], word);
    end
    if (op == OP_MUL) begin
      m_regs[REG_DX] = exp_res[31:16];
    end
    if (op == OP_SAVEIP) begin
      m_regs[REG_IPSAVE] = m_regs[REG_IP];
    end
    m_flags = exp_fl;
  endtask

  task automatic idle();
    @(posedge clk);
    uop_valid <= 1'b0;
    uop_op    <= OP_NOP;
    @(negedge clk);
    check_state();
    check_bit("cx_zero", cx_zero, m_regs[REG_CX] == 16'h0000);
  endtask

  function automatic word_t rand_word();
    logic [31:0] v;
    v = $urandom;
    return v[15:0];
  endfunction

  function automatic reg_addr_t rand_reg();
    logic [31:0] v;
    v = $urandom;
    return v[3:0];
  endfunction

  function automatic logic rand_bit();
    logic [31:0] v;
    v = $urandom;
    return v[0];
  endfunction

  function automatic exec_op_e pick_alu_op();
    case ($urandom % 6)
      0:       return OP_MOV;
      1:       return OP_ADD;
      2:       return OP_SUB;
      3:       return OP_AND;
      4:       return OP_OR;
      default: return OP_XOR;
    endcase
  endfunction

  // multiply targets exclude DX, which takes the high word.
  function automatic reg_addr_t pick_mul_dst();
    case ($urandom % 6)
      0:       return 4'd0;
      1:       return 4'd1;
      2:       return 4'd3;
      3:       return 4'd6;
      4:       return 4'd12;
      default: return 4'd13;
    endcase
  endfunction

  task automatic end_test(input string name, input int err0, input int chk0);
    $display("%s: %0d checks, %0d errors", name, checks - chk0, errors - err0);
  endtask

  // ##########################################################################
  // test sequence
  // ##########################################################################

  initial begin
    int    cycles;
    int    err0;
    int    chk0;
    word_t v;
    void'($urandom(32'h15d36469));
    errors = 0;
    checks = 0;
    for (int i = 0; i < 16; i++) begin
      m_regs[i] = 16'h0000;
    end
    m_regs[REG_CS] = CS_RESET;
    m_regs[REG_IP] = IP_RESET;
    m_flags        = '0;

    cycles = 0;
    while (rst !== 1'b0 && cycles < 20) begin
      @(posedge clk);
      cycles++;
    end
    if (rst !== 1'b0) begin
      $display("reset was not released within 20 cycles");
      $display("test failed");
      $finish;
    end

    err0 = errors;
    chk0 = checks;
    @(negedge clk);
    check_word("cs", cs, CS_RESET);
    check_word("ip", ip, IP_RESET);
    check_flags("flags", flags, '0);
    check_bit("cx_zero", cx_zero, 1'b1);
    end_test("reset values", err0, chk0);

    // random word operations, every one possibly reading the last write.
    err0 = errors;
    chk0 = checks;
    issue(OP_MOV, 4'd3, 4'd0, 1'b1, 16'h7fff, 1'b1);
    issue(OP_ADD, 4'd3, 4'd3, 1'b0, 16'h0000, 1'b1);
    repeat (300) begin
      issue(pick_alu_op(), rand_reg(), rand_reg(), rand_bit(), rand_word(), 1'b1);
    end
    idle();
    end_test("word alu", err0, chk0);

    // byte writes into 0-7 mixed with word moves that expose both halves.
    err0 = errors;
    chk0 = checks;
    repeat (300) begin
      if ($urandom % 3 == 0) begin
        issue(OP_MOV, rand_bit() ? 4'd13 : 4'd12, rand_reg() & 4'h7, 1'b0,
              16'h0000, 1'b1);
      end else begin
        issue(pick_alu_op(), rand_reg() & 4'h7, rand_reg(), rand_bit(),
              rand_word(), 1'b0);
      end
    end
    idle();
    end_test("byte halves", err0, chk0);

    // the high product word is read back from DX right away.
    err0 = errors;
    chk0 = checks;
    issue(OP_MOV, 4'd0, 4'd0, 1'b1, 16'hffff, 1'b1);
    issue(OP_MUL, 4'd0, 4'd0, 1'b1, 16'h0001, 1'b1);
    issue(OP_MUL, 4'd0, 4'd0, 1'b1, 16'hffff, 1'b1);
    repeat (150) begin
      issue(OP_MUL, pick_mul_dst(), rand_reg(), rand_bit(), rand_word(), 1'b1);
      issue(OP_MOV, 4'd13, REG_DX, 1'b0, 16'h0000, 1'b1);
    end
    idle();
    end_test("multiply", err0, chk0);

    // small counts in CX and CH so that zero comes up often.
    err0 = errors;
    chk0 = checks;
    issue(OP_MOV, REG_CX, 4'd0, 1'b1, 16'h0005, 1'b1);
    issue(OP_MOV, REG_CX, 4'd0, 1'b1, 16'h0000, 1'b1);
    issue(OP_SUB, REG_CX, REG_CX, 1'b0, 16'h0000, 1'b1);
    repeat (150) begin
      v = rand_word() & 16'h0003;
      issue(pick_alu_op(), rand_bit() ? 4'd5 : REG_CX, rand_reg(), 1'b1, v, rand_bit());
    end
    idle();
    end_test("cx zero", err0, chk0);

    // a jump target goes into IP and the save slot keeps it.
    err0 = errors;
    chk0 = checks;
    repeat (20) begin
      v = rand_word();
      issue(OP_MOV, REG_IP, 4'd0, 1'b1, v, 1'b1);
      issue(OP_SAVEIP, 4'd0, 4'd0, 1'b0, 16'h0000, 1'b1);
      check_word("ip", ip, v);
      issue(OP_MOV, 4'd13, REG_IPSAVE, 1'b0, 16'h0000, 1'b1);
      check_word("saved ip", result[15:0], v);
    end
    idle();
    end_test("ip save", err0, chk0);

    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* build.f */
verilog/exec_pkg.sv
verilog/regfile_if.sv
verilog/exec_alu.sv
verilog/exec_regfile.sv
verilog/exec_uop_ctrl.sv
verilog/exec_unit.sv
sim/tb_exec_unit.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_exec_unit
RTL_TOP  = exec_unit
FILELIST = build.f
BIN      = obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

lint:
	$(TOOL) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
